// File: hw/vgc_timing_pkg.sv
package vgc_timing_pkg;

    // Raster counter widths
    localparam int h_w = 10;
    localparam int v_w = 9;

    // Raster position as it arrives from the external counters
    typedef struct packed {
        logic [h_w-1:0] h;  // Pixel column
        logic [v_w-1:0] v;  // Scan line
    } raster_t;

    // Active SHR window, 640 columns by 192 lines
    localparam logic [h_w-1:0] win_left   = 10'd32;
    localparam logic [h_w-1:0] win_right  = 10'd671;
    localparam logic [v_w-1:0] win_top    = 9'd16;
    localparam logic [v_w-1:0] win_bottom = 9'd207;

    // Palette bytes are fetched in columns 0..31 of the left border
    localparam logic [h_w-1:0] h_pal_last = 10'd31;

    // End-of-line events in the right border
    localparam logic [h_w-1:0] h_scb_addr  = 10'h38c;  // SCB address goes out
    localparam logic [h_w-1:0] h_scb_load  = 10'h38e;  // SCB byte captured
    localparam logic [h_w-1:0] h_irq_clear = 10'h390;  // Scanline IRQ dropped

    // First line below the window
    localparam logic [v_w-1:0] v_vbl = 9'd208;

endpackage

// File: hw/shr_mem_pkg.sv
package shr_mem_pkg;

    // Video memory address width
    localparam int vaddr_w = 23;

    // SHR bank layout, offsets from the bank base
    localparam logic [vaddr_w-1:0] pix_base_off = 23'h00000;  // 200 lines of 160 bytes
    localparam logic [vaddr_w-1:0] scb_off      = 23'h07d00;  // One SCB per line
    localparam logic [vaddr_w-1:0] pal_off      = 23'h07e00;  // 16 palettes

    localparam int line_bytes = 160;
    localparam int pal_bytes  = 32;  // 16 colours of two bytes

    // Scanline control byte
    typedef struct packed {
        logic       mode_640;  // 640 columns, 2 bits per pixel
        logic       irq_en;    // Raise scanline IRQ for this line
        logic       fill;      // 320 mode fill, colour 0 repeats
        logic       rsvd;
        logic [3:0] pal_sel;   // Palette used by this line
    } scb_t;

    // 320 mode view of a pixel byte
    typedef struct packed {
        logic [3:0] hi;  // Left pixel
        logic [3:0] lo;  // Right pixel
    } pix_nib_t;

    // Same byte, decoded per line mode
    typedef union packed {
        pix_nib_t        nib;    // 320 mode
        logic [3:0][1:0] crumb;  // 640 mode, crumb[3] is the leftmost pixel
    } pix_byte_u;

    // 4 bits per gun
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    // One palette byte write
    typedef struct packed {
        logic       strobe;
        logic [3:0] index;     // Palette entry
        logic       odd_byte;  // Red byte, else green/blue byte
    } pal_wr_t;

    // Fixed IIgs colours, used for the border
    localparam rgb12_t border_table [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d,  // Black, deep red, dark blue, purple
        12'h072, 12'h555, 12'h22f, 12'h6af,  // Greens and blues
        12'h850, 12'hf60, 12'haaa, 12'hf98,  // Brown, orange, grey, pink
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff   // Light green to white
    };

endpackage

// File: hw/shr_line_fetch.sv
`timescale 1ns/100ps

module shr_line_fetch
    import vgc_timing_pkg::*;
    import shr_mem_pkg::*;
#(
    parameter logic [vaddr_w-1:0] shr_base = 23'h12000
) (
    input  logic               clk_vid,
    input  logic               rst_n,
    input  logic               ce_pix,
    input  raster_t            raster,
    input  logic [7:0]         video_data,
    input  logic               shr_enable,
    output logic [vaddr_w-1:0] video_addr,
    output scb_t               scb,
    output pal_wr_t            pal_wr,
    output logic [7:0]         pal_byte,
    output pix_byte_u          pix_byte,
    output logic               scanline_irq
);

    scb_t               scb_in;       // Memory byte seen as an SCB
    logic               in_pal;       // Palette fetch columns
    logic               in_pix;       // Pixel fetch columns
    logic               irq_line_ok;  // Lines that may raise the scanline IRQ
    logic [vaddr_w-1:0] v_rel;        // Line number inside the window
    logic [vaddr_w-1:0] scb_addr;
    logic [vaddr_w-1:0] pal_addr;
    logic [vaddr_w-1:0] pix_addr;

    assign scb_in = scb_t'(video_data);

    assign in_pal = raster.h <= h_pal_last;
    assign in_pix = raster.h >= win_left && raster.h <= win_right;

    // Lines 16..205
    assign irq_line_ok = raster.v >= win_top && raster.v < win_bottom - 1'b1;

    // Wraps above the window, harmless there
    assign v_rel = vaddr_w'(raster.v) - vaddr_w'(win_top);

    // Fetched at the end of a line, so the SCB is the next line's one
    assign scb_addr = shr_base + scb_off + v_rel + 1'b1;
    assign pal_addr = shr_base + pal_off + vaddr_w'(scb_in.pal_sel) * vaddr_w'(pal_bytes);
    assign pix_addr = shr_base + pix_base_off + v_rel * vaddr_w'(line_bytes);

    // Address sequence and SCB capture
    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            video_addr   <= '0;
            scb          <= '0;
            scanline_irq <= 1'b0;
        end else if (ce_pix) begin
            if (raster.h == h_scb_addr) begin
                video_addr <= scb_addr;
            end else if (raster.h == h_scb_load) begin
                scb        <= scb_in;
                video_addr <= pal_addr;  // Palette of the new line
                if (scb_in.irq_en && shr_enable && irq_line_ok) begin
                    scanline_irq <= 1'b1;
                end
            end else if (raster.h == h_irq_clear) begin
                scanline_irq <= 1'b0;
            end else if (raster.h == h_pal_last) begin
                video_addr <= pix_addr;  // Last palette byte, jump to pixel data
            end else if (in_pal) begin
                video_addr <= video_addr + 1'b1;
            end else if (in_pix && raster.h[1:0] == 2'd3) begin
                // Window starts on a multiple of 4, so h[1:0] is the sub-position
                video_addr <= video_addr + 1'b1;
            end
        end
    end

    // One byte covers four columns
    always_ff @(posedge clk_vid) begin
        if (ce_pix && in_pix && raster.h[1:0] == 2'd0) begin
            pix_byte <= pix_byte_u'(video_data);
        end
    end

    // Palette bytes in memory order, green/blue first then red
    always_comb begin
        pal_wr.strobe   = ce_pix && in_pal;
        pal_wr.index    = raster.h[4:1];  // Two bytes per entry
        pal_wr.odd_byte = raster.h[0];
    end

    assign pal_byte = video_data;

endmodule

// File: hw/shr_palette.sv
`timescale 1ns/100ps

module shr_palette
    import shr_mem_pkg::*;
(
    input  logic          clk_vid,
    input  pal_wr_t       pal_wr,
    input  logic [7:0]    pal_byte,
    output rgb12_t [15:0] pal_rd
);

    // Colours of the current line
    rgb12_t pal_mem [16];

    // Strobe already carries the pixel enable
    always_ff @(posedge clk_vid) begin
        if (pal_wr.strobe) begin
            if (pal_wr.odd_byte) begin
                pal_mem[pal_wr.index].r <= pal_byte[3:0];  // High nibble unused
            end else begin
                pal_mem[pal_wr.index].g <= pal_byte[7:4];
                pal_mem[pal_wr.index].b <= pal_byte[3:0];
            end
        end
    end

    // Every entry visible at once for the decoder's lookup
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            pal_rd[i] = pal_mem[i];
        end
    end

endmodule

// File: hw/shr_pixel_decode.sv
`timescale 1ns/100ps

module shr_pixel_decode
    import vgc_timing_pkg::*;
    import shr_mem_pkg::*;
(
    input  logic          clk_vid,
    input  logic          rst_n,
    input  logic          ce_pix,
    input  raster_t       raster,
    input  scb_t          scb,
    input  pix_byte_u     pix_byte,
    input  rgb12_t [15:0] pal_rd,
    output rgb12_t        pix_color
);

    logic [h_w-1:0] col_h;       // Column being decoded, one behind the raster
    logic [1:0]     sub_pos;     // Pixel inside the fetched byte
    logic           col_in_win;
    logic [3:0]     nib;         // 320 mode nibble for this column
    logic [3:0]     idx_320;
    logic [3:0]     idx_640;
    logic [3:0]     pix_idx;
    logic [3:0]     last_idx;    // Fill mode memory

    assign sub_pos    = col_h[1:0];
    assign col_in_win = col_h >= win_left && col_h <= win_right;

    // 320 mode: each nibble spans two columns
    assign nib     = sub_pos[1] ? pix_byte.nib.lo : pix_byte.nib.hi;
    assign idx_320 = (scb.fill && nib == 4'd0) ? last_idx : nib;

    // 640 mode: crumbs left to right use banks 8, 12, 0, 4
    assign idx_640 = {~sub_pos[1], sub_pos[0], pix_byte.crumb[~sub_pos]};

    assign pix_idx = scb.mode_640 ? idx_640 : idx_320;

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            col_h    <= '0;
            last_idx <= '0;
        end else if (ce_pix) begin
            col_h <= raster.h;
            if (raster.h == h_pal_last) begin
                last_idx <= '0;  // Each line starts from colour 0
            end else if (col_in_win && !scb.mode_640) begin
                last_idx <= idx_320;
            end
        end
    end

    // Colour of col_h, ready one edge later for the output stage
    always_ff @(posedge clk_vid) begin
        if (ce_pix) begin
            pix_color <= pal_rd[pix_idx];
        end
    end

endmodule

// File: hw/vgc_video_out.sv
`timescale 1ns/100ps

module vgc_video_out
    import vgc_timing_pkg::*;
    import shr_mem_pkg::*;
(
    input  logic       clk_vid,
    input  logic       rst_n,
    input  logic       ce_pix,
    input  raster_t    raster,
    input  logic       shr_enable,
    input  logic [3:0] border_color,
    input  rgb12_t     pix_color,
    output logic [7:0] rgb_r,
    output logic [7:0] rgb_g,
    output logic [7:0] rgb_b,
    output logic       vbl_irq
);

    raster_t        raster_d;    // Raster of the previous edge
    logic [h_w-1:0] col_h;       // Column whose colour sits in pix_color
    logic           h_in_win;
    logic           v_in_win;
    logic           show_pix;
    rgb12_t         border_rgb;
    rgb12_t         out_rgb;

    // pix_color trails raster_d by one more column
    assign col_h = raster_d.h - 1'b1;

    assign h_in_win = col_h >= win_left && col_h <= win_right;
    assign v_in_win = raster_d.v >= win_top && raster_d.v <= win_bottom;
    assign show_pix = shr_enable && h_in_win && v_in_win;

    assign border_rgb = border_table[border_color];
    assign out_rgb    = show_pix ? pix_color : border_rgb;

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            raster_d <= '0;
            rgb_r    <= '0;
            rgb_g    <= '0;
            rgb_b    <= '0;
            vbl_irq  <= 1'b0;
        end else if (ce_pix) begin
            raster_d <= raster;
            // Nibble doubling gives full-scale 8-bit guns
            rgb_r    <= {out_rgb.r, out_rgb.r};
            rgb_g    <= {out_rgb.g, out_rgb.g};
            rgb_b    <= {out_rgb.b, out_rgb.b};
            vbl_irq  <= raster.v == v_vbl;  // Whole line below the window
        end
    end

endmodule

// File: hw/vgc_top.sv
`timescale 1ns/100ps

module vgc_top
    import vgc_timing_pkg::*;
    import shr_mem_pkg::*;
#(
    parameter logic [vaddr_w-1:0] shr_base = 23'h12000  // SHR bank in the flat video space
) (
    input  logic               clk_vid,
    input  logic               rst_n,
    input  logic               ce_pix,
    input  raster_t            raster,
    input  logic [7:0]         video_data,
    input  logic               shr_enable,
    input  logic [3:0]         border_color,
    output logic [vaddr_w-1:0] video_addr,
    output logic [7:0]         rgb_r,
    output logic [7:0]         rgb_g,
    output logic [7:0]         rgb_b,
    output logic               scanline_irq,
    output logic               vbl_irq
);

    scb_t          scb;        // Control byte of the current line
    pal_wr_t       pal_wr;
    logic [7:0]    pal_byte;
    pix_byte_u     pix_byte;   // Latched pixel byte
    rgb12_t [15:0] pal_rd;
    rgb12_t        pix_color;  // Decoded colour, one column behind

    // Memory sequencer
    shr_line_fetch #(
        .shr_base (shr_base)
    ) i_line_fetch (
        .clk_vid      (clk_vid),
        .rst_n        (rst_n),
        .ce_pix       (ce_pix),
        .raster       (raster),
        .video_data   (video_data),
        .shr_enable   (shr_enable),
        .video_addr   (video_addr),
        .scb          (scb),
        .pal_wr       (pal_wr),
        .pal_byte     (pal_byte),
        .pix_byte     (pix_byte),
        .scanline_irq (scanline_irq)
    );

    shr_palette i_palette (
        .clk_vid  (clk_vid),
        .pal_wr   (pal_wr),
        .pal_byte (pal_byte),
        .pal_rd   (pal_rd)
    );

    shr_pixel_decode i_pixel_decode (
        .clk_vid   (clk_vid),
        .rst_n     (rst_n),
        .ce_pix    (ce_pix),
        .raster    (raster),
        .scb       (scb),
        .pix_byte  (pix_byte),
        .pal_rd    (pal_rd),
        .pix_color (pix_color)
    );

    // Border select and RGB registers
    vgc_video_out i_video_out (
        .clk_vid      (clk_vid),
        .rst_n        (rst_n),
        .ce_pix       (ce_pix),
        .raster       (raster),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .pix_color    (pix_color),
        .rgb_r        (rgb_r),
        .rgb_g        (rgb_g),
        .rgb_b        (rgb_b),
        .vbl_irq      (vbl_irq)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    output logic clk_vid,
    output logic rst_n
);

    initial begin
        clk_vid = 1'b0;
        forever #(period_ns / 2) clk_vid = ~clk_vid;
    end

    // Released on a rising edge like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_vid);
        rst_n <= 1'b1;
    end

endmodule

// File: sim/tb_vgc.sv
`timescale 1ns/100ps

module tb_vgc
    import vgc_timing_pkg::*;
    import shr_mem_pkg::*;
();

    localparam logic [vaddr_w-1:0] shr_base_addr = 23'h12000;
    localparam logic [h_w-1:0]     h_last        = 10'h391;  // Sweep reaches the IRQ clear
    localparam int line_cycles = 18 + 914;                   // Prelude plus one full line
    localparam int n_lines     = 22;
    localparam int watchdog_ns = (n_lines * line_cycles + 100) * 100;

    // IIgs standard colours
    localparam logic [11:0] border_ref [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d, 12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98, 12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

    typedef struct packed {
        raster_t    pos;
        logic       en;      // SHR enable
        logic [3:0] border;
    } stim_t;

    logic               clk_vid;
    logic               rst_n;
    logic               ce_pix;
    raster_t            raster;
    logic [7:0]         video_data;
    logic               shr_enable;
    logic [3:0]         border_color;
    logic [vaddr_w-1:0] video_addr;
    logic [7:0]         rgb_r;
    logic [7:0]         rgb_g;
    logic [7:0]         rgb_b;
    logic               scanline_irq;
    logic               vbl_irq;

    logic [7:0]         vmem [32768];  // SHR bank
    logic [vaddr_w-1:0] vid_off;
    logic [31:0]        rng;
    stim_t              cur;           // Stimulus the next edge samples

    // Reference model state
    logic [vaddr_w-1:0] m_addr;
    scb_t               m_scb;
    logic               m_irq;
    logic               m_vbl;
    rgb12_t             m_pal [16];
    logic [7:0]         m_pix;
    logic [3:0]         m_last;       // Last non-zero nibble of the line
    logic [h_w-1:0]     m_col_h;
    rgb12_t             m_pix_color;
    raster_t            m_rd;
    rgb12_t             m_rgb;

    int errors;
    int err_mark;
    int tests_run;
    int tests_failed;
    int irq_seen;
    int vbl_seen;

    tb_clock #(.period_ns(100), .reset_cycles(4)) i_clock (
        .clk_vid (clk_vid),
        .rst_n   (rst_n)
    );

    vgc_top #(
        .shr_base (shr_base_addr)
    ) i_vgc_top (
        .clk_vid      (clk_vid),
        .rst_n        (rst_n),
        .ce_pix       (ce_pix),
        .raster       (raster),
        .video_data   (video_data),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_addr   (video_addr),
        .rgb_r        (rgb_r),
        .rgb_g        (rgb_g),
        .rgb_b        (rgb_b),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Outside the bank, a pattern of the whole address
    function automatic logic [7:0] fill_byte(input logic [vaddr_w-1:0] addr);
        return addr[7:0] ^ addr[15:8] ^ {1'b0, addr[22:16]} ^ 8'h5a;
    endfunction

    function automatic logic [7:0] mem_rd(input logic [vaddr_w-1:0] addr);
        logic [vaddr_w-1:0] off;
        off = addr - shr_base_addr;
        return (off < 23'h8000) ? vmem[off[14:0]] : fill_byte(addr);
    endfunction

    // Combinational memory, data follows the address
    always_comb begin
        vid_off = video_addr - shr_base_addr;
        if (vid_off < 23'h8000) begin
            video_data = vmem[vid_off[14:0]];
        end else begin
            video_data = fill_byte(video_addr);
        end
    end

    task automatic fill_mem();
        for (int i = 0; i < 32768; i++) begin
            vmem[i] = 8'(next_rand());
        end
    endtask

    task automatic set_scb(input logic [v_w-1:0] v, input logic [7:0] scb_byte);
        vmem[15'(scb_off + v - 16)] = scb_byte;  // Window lines only
    endtask

    // One ce edge of the reference model, s is what the DUT sampled
    task automatic model_edge(input stim_t s);
        logic [h_w-1:0]     h;
        logic [h_w-1:0]     col;
        logic [1:0]         sub;
        logic [3:0]         nib;
        logic [3:0]         idx;
        logic [7:0]         d;
        logic [vaddr_w-1:0] vrel;
        h = s.pos.h;
        col = m_rd.h - 1'b1;  // Output stage is two columns behind
        if (s.en && col >= 32 && col <= 671 && m_rd.v >= 16 && m_rd.v <= 207) begin
            m_rgb = m_pix_color;
        end else begin
            m_rgb = rgb12_t'(border_ref[s.border]);
        end
        m_rd  = s.pos;
        m_vbl = (s.pos.v == 9'd208);
        // Decoder works on the previous column
        col = m_col_h;
        sub = 2'(col - 10'd32);
        nib = (sub < 2'd2) ? m_pix[7:4] : m_pix[3:0];
        if (m_scb.mode_640) begin
            case (sub)
                2'd0:    idx = 4'd8 + 4'(m_pix[7:6]);
                2'd1:    idx = 4'd12 + 4'(m_pix[5:4]);
                2'd2:    idx = 4'(m_pix[3:2]);
                default: idx = 4'd4 + 4'(m_pix[1:0]);
            endcase
        end else begin
            idx = (m_scb.fill && nib == 4'd0) ? m_last : nib;
        end
        m_pix_color = m_pal[idx];  // Palette before this edge's write
        if (h == 10'd31) begin
            m_last = 4'd0;
        end else if (col >= 32 && col <= 671 && !m_scb.mode_640 && nib != 4'd0) begin
            m_last = nib;
        end
        m_col_h = h;
        d = mem_rd(m_addr);
        if (h <= 10'd31) begin
            if (h[0]) begin
                m_pal[h / 2].r = d[3:0];  // Red byte
            end else begin
                m_pal[h / 2].g = d[7:4];
                m_pal[h / 2].b = d[3:0];
            end
        end
        if (h >= 32 && h <= 671 && (h - 32) % 4 == 0) begin
            m_pix = d;
        end
        vrel = vaddr_w'(s.pos.v) - 23'd16;
        if (h == 10'h38c) begin
            m_addr = shr_base_addr + scb_off + vaddr_w'(s.pos.v) - 23'd15;
        end else if (h == 10'h38e) begin
            m_scb  = scb_t'(d);
            m_addr = shr_base_addr + pal_off + 23'(m_scb.pal_sel) * 23'd32;
            if (m_scb.irq_en && s.en && s.pos.v > 15 && s.pos.v < 206) begin
                m_irq = 1'b1;
            end
        end else if (h == 10'h390) begin
            m_irq = 1'b0;
        end else if (h == 10'd31) begin
            m_addr = shr_base_addr + pix_base_off + vrel * 23'd160;
        end else if (h < 10'd31 || (h >= 32 && h <= 671 && (h - 32) % 4 == 3)) begin
            m_addr = m_addr + 1'b1;
        end
    endtask

    task automatic check_outputs();
        assert (video_addr === m_addr) else begin
            errors++;
            $display("error at %0t: video_addr %h, expected %h", $time, video_addr, m_addr);
        end
        assert ({rgb_r, rgb_g, rgb_b} ===
                {m_rgb.r, m_rgb.r, m_rgb.g, m_rgb.g, m_rgb.b, m_rgb.b}) else begin
            errors++;
            $display("error at %0t: rgb %h%h%h, expected %h", $time, rgb_r, rgb_g, rgb_b, m_rgb);
        end
        assert (scanline_irq === m_irq) else begin
            errors++;
            $display("error at %0t: scanline_irq %b, expected %b", $time, scanline_irq, m_irq);
        end
        assert (vbl_irq === m_vbl) else begin
            errors++;
            $display("error at %0t: vbl_irq %b, expected %b", $time, vbl_irq, m_vbl);
        end
        irq_seen += int'(scanline_irq === 1'b1);
        vbl_seen += int'(vbl_irq === 1'b1);
    endtask

    // Drive the next position, update the model for the edge, check at the falling edge
    task automatic tick(input stim_t nxt);
        @(posedge clk_vid);
        raster       <= nxt.pos;
        shr_enable   <= nxt.en;
        border_color <= nxt.border;
        model_edge(cur);
        cur = nxt;
        @(negedge clk_vid);
        check_outputs();
    endtask

    // End of the line before loads the SCB, then a full sweep of line v
    task automatic run_line(input logic [v_w-1:0] v, input logic en, input logic [3:0] border);
        stim_t s;
        s.en     = en;
        s.border = border;
        s.pos.v  = v - 1'b1;
        for (int h = 10'h380; h <= h_last; h++) begin
            s.pos.h = 10'(h);
            tick(s);
        end
        s.pos.v = v;
        for (int h = 0; h <= h_last; h++) begin
            s.pos.h = 10'(h);
            tick(s);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %-10s %s, %0d errors", name,
                 (errors == err_mark) ? "passed" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        logic [v_w-1:0] v;
        logic [7:0]     sb;
        ce_pix       = 1'b1;
        raster       = '{h: 10'h3f0, v: 9'd0};  // Parked outside the window
        shr_enable   = 1'b0;
        border_color = 4'd0;
        rng          = 32'h41f9;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        cur = '{pos: '{h: 10'h3f0, v: 9'd0}, en: 1'b0, border: 4'd0};
        m_addr = '0;  // Reset values
        m_scb = '0;
        m_irq = 1'b0;
        m_vbl = 1'b0;
        m_pix = '0;
        m_last = '0;
        m_col_h = '0;
        m_pix_color = '0;
        m_rd = '0;
        m_rgb = '0;
        for (int i = 0; i < 16; i++) begin
            m_pal[i] = '0;
        end
        wait (rst_n === 1'b1);
        @(negedge clk_vid);
        check_outputs();
        finish_test("reset");

        fill_mem();
        for (int k = 0; k < 4; k++) begin
            v = 9'(16 + next_rand() % 192);
            set_scb(v, 8'(next_rand()));
            run_line(v, 1'b1, 4'(next_rand()));
        end
        finish_test("address");

        fill_mem();
        for (int k = 0; k < 4; k++) begin
            v  = 9'(16 + next_rand() % 192);
            sb = 8'(next_rand());
            set_scb(v, {1'b0, sb[6], 1'(k), sb[4:0]});  // Fill on odd lines
            run_line(v, 1'b1, 4'(next_rand()));
        end
        finish_test("320_mode");

        fill_mem();
        for (int k = 0; k < 4; k++) begin
            v = 9'(16 + next_rand() % 192);
            set_scb(v, 8'(next_rand()) | 8'h80);
            run_line(v, 1'b1, 4'(next_rand()));
        end
        finish_test("640_mode");

        fill_mem();
        run_line(9'(16 + next_rand() % 192), 1'b0, 4'(next_rand()));
        run_line(9'd3, 1'b1, 4'(next_rand()));    // Above the window
        run_line(9'd230, 1'b1, 4'(next_rand()));  // Below it
        run_line(9'd207, 1'b0, 4'(next_rand()));
        finish_test("border");

        fill_mem();
        for (int i = 16; i < 216; i++) begin
            set_scb(9'(i), 8'(next_rand()) | 8'h40);  // Every line asks for the IRQ
        end
        irq_seen = 0;
        vbl_seen = 0;
        run_line(9'd15, 1'b1, 4'(next_rand()));
        run_line(9'd16, 1'b1, 4'(next_rand()));
        run_line(9'd100, 1'b0, 4'(next_rand()));  // Masked by the SHR enable
        run_line(9'd205, 1'b1, 4'(next_rand()));
        run_line(9'd206, 1'b1, 4'(next_rand()));
        run_line(9'd208, 1'b1, 4'(next_rand()));
        assert (irq_seen > 0 && vbl_seen > 0) else begin
            errors++;
            $display("The interrupt test never saw a scanline or vertical-blank interrupt");
        end
        finish_test("interrupts");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Swept cycles plus a margin
    initial begin
        #(watchdog_ns * 1ns);
        $display("Timeout at %0t, the tests did not complete in time", $time);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: flist.f
hw/vgc_timing_pkg.sv
hw/shr_mem_pkg.sv
hw/shr_line_fetch.sv
hw/shr_palette.sv
hw/shr_pixel_decode.sv
hw/vgc_video_out.sv
hw/vgc_top.sv
sim/tb_clock.sv
sim/tb_vgc.sv

// File: Bender.yml
package:
  name: vgc_shr

sources:
  - files:
      - hw/vgc_timing_pkg.sv
      - hw/shr_mem_pkg.sv
      - hw/shr_line_fetch.sv
      - hw/shr_palette.sv
      - hw/shr_pixel_decode.sv
      - hw/vgc_video_out.sv
      - hw/vgc_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_vgc.sv
